//--- Bender.yml
package:
  name: branch_predictor

sources:
  - src/bp_pkg.sv
  - src/bp_update_if.sv
  - src/btb.sv
  - src/history_regs.sv
  - src/pht.sv
  - src/bp_update_ctrl.sv
  - src/perf_counters.sv
  - src/branch_predictor.sv
  - target: test
    files:
      - tests/tb_branch_predictor.sv

//--- files.f
src/bp_pkg.sv
src/bp_update_if.sv
src/btb.sv
src/history_regs.sv
src/pht.sv
src/bp_update_ctrl.sv
src/perf_counters.sv
src/branch_predictor.sv
tests/tb_branch_predictor.sv

//--- src/bp_pkg.sv
package bp_pkg;

    // instruction addresses and jump targets
    typedef logic [31:0] word_t;

    // kind of control instruction held in the btb
    typedef enum logic [1:0] {
        cf_br   = 2'b00,
        cf_jal  = 2'b01,
        cf_jalr = 2'b10
    } cf_kind_t;

    // global and local history
    localparam int HISTORY_DEPTH = 6;
    typedef logic [HISTORY_DEPTH-1:0] ghist_t;   // also the pht index

    // branch target buffer geometry
    localparam int BTB_S_INDEX = 4;
    localparam int BTB_ENTRIES = 1 << BTB_S_INDEX;
    localparam int BTB_TAG_WIDTH = 32 - BTB_S_INDEX - 2;   // pc bits above the index
    typedef logic [BTB_S_INDEX-1:0] btb_index_t;
    typedef logic [BTB_TAG_WIDTH-1:0] btb_tag_t;

    // per-address local history table
    localparam int BHT_S_INDEX = 4;
    localparam int BHT_ENTRIES = 1 << BHT_S_INDEX;
    typedef logic [BHT_S_INDEX-1:0] bht_index_t;

    // tournament chooser, indexed by word address
    localparam int CHOOSER_S_INDEX = 5;
    typedef logic [CHOOSER_S_INDEX-1:0] chooser_index_t;

    // 2-bit saturating counter, top bit is the decision
    typedef logic [1:0] ctr2_t;

    // weakly not taken, for the chooser weakly prefer local
    localparam ctr2_t PHT_RESET_STATE = 2'b01;

    // performance counters
    localparam int PERF_CNT_WIDTH = 16;
    typedef logic [PERF_CNT_WIDTH-1:0] perf_cnt_t;

endpackage : bp_pkg

//--- src/bp_update_ctrl.sv
`timescale 1ns/1ps

module bp_update_ctrl
    import bp_pkg::*;
(
    bp_update_if.ctrl upd,
    input  ctr2_t     global_ctr_at_update,
    input  ctr2_t     local_ctr_at_update
);

    logic is_br;
    logic disagree;
    logic global_right;

    assign is_br = upd.valid && (upd.kind == cf_br);

    // predictors split on the direction they gave
    assign disagree     = global_ctr_at_update[1] != local_ctr_at_update[1];
    assign global_right = global_ctr_at_update[1] == upd.taken;

    always_comb begin
        upd.btb_load     = upd.valid;   // every control instruction refreshes its entry
        upd.history_load = is_br;
        upd.pht_inc      = is_br && upd.taken;
        upd.pht_dec      = is_br && !upd.taken;

        // chooser moves toward whichever table was right
        upd.chooser_inc  = is_br && disagree && global_right;
        upd.chooser_dec  = is_br && disagree && !global_right;
    end

    assert property (@(posedge upd.clk) upd.valid |-> !$isunknown(upd.kind))
        else $error("resolve with unknown kind");

endmodule : bp_update_ctrl

//--- src/bp_update_if.sv
`timescale 1ns/1ps

interface bp_update_if
    import bp_pkg::*;
(
    input logic clk
);

    // resolved control instruction
    logic     valid;
    word_t    pc;
    cf_kind_t kind;
    logic     taken;
    word_t    target;
    logic     pred_taken;     // direction that fetch was given
    ghist_t   global_index;   // indexes used at lookup
    ghist_t   local_index;

    // update strobes
    logic btb_load;
    logic history_load;
    logic pht_inc;
    logic pht_dec;
    logic chooser_inc;
    logic chooser_dec;

    modport ctrl (
        input  clk, valid, kind, taken,
        output btb_load, history_load, pht_inc, pht_dec, chooser_inc, chooser_dec
    );

    modport source (
        output valid, pc, kind, taken, target, pred_taken, global_index, local_index
    );

    modport btb  (input pc, kind, target, btb_load);
    modport hist (input pc, taken, history_load);
    modport perf (input valid, kind, taken, pred_taken);

endinterface : bp_update_if

//--- src/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor
    import bp_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,

    // fetch side lookup
    input  word_t     fetch_pc,
    output logic      pred_hit,
    output cf_kind_t  pred_kind,
    output word_t     pred_target,
    output logic      pred_taken,
    output ghist_t    pred_global_index,
    output ghist_t    pred_local_index,

    // resolve side
    input  logic      resolve_valid,
    input  word_t     resolve_pc,
    input  cf_kind_t  resolve_kind,
    input  logic      resolve_taken,
    input  word_t     resolve_target,
    input  logic      resolve_pred_taken,
    input  ghist_t    resolve_global_index,
    input  ghist_t    resolve_local_index,

    // performance counters
    output perf_cnt_t num_control_flow,
    output perf_cnt_t num_br,
    output perf_cnt_t num_correct_predict,
    output logic      num_control_flow_overflow,
    output logic      num_br_overflow,
    output logic      num_correct_predict_overflow
);

    ctr2_t          global_ctr;
    ctr2_t          local_ctr;
    ctr2_t          chooser_ctr;
    ctr2_t          global_ctr_upd;
    ctr2_t          local_ctr_upd;
    chooser_index_t chooser_rindex;
    chooser_index_t chooser_windex;
    logic           br_pred;

    bp_update_if upd (.clk(clk));

    assign upd.valid        = resolve_valid;
    assign upd.pc           = resolve_pc;
    assign upd.kind         = resolve_kind;
    assign upd.taken        = resolve_taken;
    assign upd.target       = resolve_target;
    assign upd.pred_taken   = resolve_pred_taken;
    assign upd.global_index = resolve_global_index;
    assign upd.local_index  = resolve_local_index;

    assign chooser_rindex = fetch_pc[CHOOSER_S_INDEX+1:2];
    assign chooser_windex = resolve_pc[CHOOSER_S_INDEX+1:2];

    btb u_btb (
        .clk      (clk),
        .arst_n   (arst_n),
        .lookup_pc(fetch_pc),
        .upd      (upd.btb),
        .hit      (pred_hit),
        .kind     (pred_kind),
        .target   (pred_target)
    );

    history_regs u_history_regs (
        .clk        (clk),
        .arst_n     (arst_n),
        .lookup_pc  (fetch_pc),
        .upd        (upd.hist),
        .global_hist(pred_global_index),   // history is the pht index
        .local_hist (pred_local_index)
    );

    pht #(.s_index(HISTORY_DEPTH)) global_pht (
        .clk           (clk),
        .arst_n        (arst_n),
        .rindex        (pred_global_index),
        .windex        (upd.global_index),
        .increment     (upd.pht_inc),
        .decrement     (upd.pht_dec),
        .counter       (global_ctr),
        .update_counter(global_ctr_upd)
    );

    pht #(.s_index(HISTORY_DEPTH)) local_pht (
        .clk           (clk),
        .arst_n        (arst_n),
        .rindex        (pred_local_index),
        .windex        (upd.local_index),
        .increment     (upd.pht_inc),
        .decrement     (upd.pht_dec),
        .counter       (local_ctr),
        .update_counter(local_ctr_upd)
    );

    pht #(.s_index(CHOOSER_S_INDEX)) chooser_pht (
        .clk           (clk),
        .arst_n        (arst_n),
        .rindex        (chooser_rindex),
        .windex        (chooser_windex),
        .increment     (upd.chooser_inc),
        .decrement     (upd.chooser_dec),
        .counter       (chooser_ctr),
        .update_counter()
    );

    bp_update_ctrl u_update_ctrl (
        .upd                 (upd.ctrl),
        .global_ctr_at_update(global_ctr_upd),
        .local_ctr_at_update (local_ctr_upd)
    );

    perf_counters u_perf_counters (
        .clk                         (clk),
        .arst_n                      (arst_n),
        .upd                         (upd.perf),
        .num_control_flow            (num_control_flow),
        .num_br                      (num_br),
        .num_correct_predict         (num_correct_predict),
        .num_control_flow_overflow   (num_control_flow_overflow),
        .num_br_overflow             (num_br_overflow),
        .num_correct_predict_overflow(num_correct_predict_overflow)
    );

    // chooser top bit set selects global
    assign br_pred    = chooser_ctr[1] ? global_ctr[1] : local_ctr[1];
    assign pred_taken = pred_hit && ((pred_kind == cf_br) ? br_pred : 1'b1);   // jumps always taken

endmodule : branch_predictor

//--- src/btb.sv
`timescale 1ns/1ps

module btb
    import bp_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  word_t    lookup_pc,
    bp_update_if.btb upd,
    output logic     hit,
    output cf_kind_t kind,
    output word_t    target
);

    logic [BTB_ENTRIES-1:0] valid_q;
    btb_tag_t               tag_q    [BTB_ENTRIES];
    cf_kind_t               kind_q   [BTB_ENTRIES];
    word_t                  target_q [BTB_ENTRIES];

    btb_index_t rd_index;
    btb_tag_t   rd_tag;
    btb_index_t wr_index;
    btb_tag_t   wr_tag;
    word_t      wr_target;

    assign rd_index = lookup_pc[BTB_S_INDEX+1:2];   // word address, bits 1:0 dropped
    assign rd_tag   = lookup_pc[31:BTB_S_INDEX+2];
    assign wr_index = upd.pc[BTB_S_INDEX+1:2];
    assign wr_tag   = upd.pc[31:BTB_S_INDEX+2];

    // jalr targets are stored with bit 0 cleared
    assign wr_target = (upd.kind == cf_jalr) ? {upd.target[31:1], 1'b0} : upd.target;

    // combinational lookup
    assign hit    = valid_q[rd_index] && (tag_q[rd_index] == rd_tag);
    assign kind   = kind_q[rd_index];
    assign target = target_q[rd_index];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;                     // all entries invalid
        end else if (upd.btb_load) begin
            valid_q[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (upd.btb_load) begin
            tag_q[wr_index]    <= wr_tag;
            kind_q[wr_index]   <= upd.kind;
            target_q[wr_index] <= wr_target;
        end
    end

    // the load strobe from the update decoder must come with a resolved pc
    assert property (@(posedge clk) disable iff (!arst_n)
        upd.btb_load |-> !$isunknown(upd.pc))
        else $error("btb write with unknown pc");

endmodule : btb

//--- src/history_regs.sv
`timescale 1ns/1ps

module history_regs
    import bp_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  word_t     lookup_pc,
    bp_update_if.hist upd,
    output ghist_t    global_hist,
    output ghist_t    local_hist
);

    ghist_t     global_q;
    ghist_t     local_q [BHT_ENTRIES];
    bht_index_t rd_index;
    bht_index_t wr_index;

    assign rd_index = lookup_pc[BHT_S_INDEX+1:2];
    assign wr_index = upd.pc[BHT_S_INDEX+1:2];

    assign global_hist = global_q;
    assign local_hist  = local_q[rd_index];   // read at the fetch pc

    // global shift register, newest outcome in bit 0
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            global_q <= '0;
        end else if (upd.history_load) begin
            global_q <= {global_q[HISTORY_DEPTH-2:0], upd.taken};
        end
    end

    // local histories, one per branch address slot
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                local_q[i] <= '0;
            end
        end else if (upd.history_load) begin
            local_q[wr_index] <= {local_q[wr_index][HISTORY_DEPTH-2:0], upd.taken};
        end
    end

endmodule : history_regs

//--- src/perf_counters.sv
`timescale 1ns/1ps

module perf_counters
    import bp_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    bp_update_if.perf upd,
    output perf_cnt_t num_control_flow,
    output perf_cnt_t num_br,
    output perf_cnt_t num_correct_predict,
    output logic      num_control_flow_overflow,
    output logic      num_br_overflow,
    output logic      num_correct_predict_overflow
);

    // slot 0 control flow, 1 branches, 2 correct predictions
    perf_cnt_t  cnt_q [3];
    logic [2:0] ovf_q;
    logic [2:0] cnt_en;

    assign cnt_en[0] = upd.valid;
    assign cnt_en[1] = upd.valid && (upd.kind == cf_br);
    assign cnt_en[2] = cnt_en[1] && (upd.taken == upd.pred_taken);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 3; i++) begin
                cnt_q[i] <= '0;
            end
            ovf_q <= '0;
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (cnt_en[i]) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;             // wraps
                    if (cnt_q[i] == '1) ovf_q[i] <= 1'b1;    // sticky
                end
            end
        end
    end

    assign num_control_flow             = cnt_q[0];
    assign num_br                       = cnt_q[1];
    assign num_correct_predict          = cnt_q[2];
    assign num_control_flow_overflow    = ovf_q[0];
    assign num_br_overflow              = ovf_q[1];
    assign num_correct_predict_overflow = ovf_q[2];

    assert property (@(posedge clk) disable iff (!arst_n)
        !$stable({cnt_q[0], cnt_q[1], cnt_q[2]}) |-> $past(upd.valid))
        else $error("perf counter moved without a resolve");

endmodule : perf_counters

//--- src/pht.sv
`timescale 1ns/1ps

module pht
    import bp_pkg::*;
#(
    parameter int s_index = HISTORY_DEPTH
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic [s_index-1:0] rindex,
    input  logic [s_index-1:0] windex,
    input  logic               increment,
    input  logic               decrement,
    output ctr2_t              counter,
    output ctr2_t              update_counter
);

    ctr2_t ctr_q [2**s_index];

    assign counter        = ctr_q[rindex];   // lookup port
    assign update_counter = ctr_q[windex];   // counter seen by the resolve

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**s_index; i++) begin
                ctr_q[i] <= PHT_RESET_STATE;
            end
        end else if (increment) begin
            if (ctr_q[windex] != 2'b11) ctr_q[windex] <= ctr_q[windex] + 2'd1;   // saturate high
        end else if (decrement) begin
            if (ctr_q[windex] != 2'b00) ctr_q[windex] <= ctr_q[windex] - 2'd1;   // saturate low
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) !(increment && decrement))
        else $error("pht increment and decrement together");

endmodule : pht

//--- tests/tb_branch_predictor.sv
`timescale 1ns/1ps

module tb_branch_predictor
    import bp_pkg::*;
();

    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 5;
    localparam int          DRIVE_DELAY  = 2;
    localparam int          SAMPLE_DELAY = 36;   // lands 2 ns before the next edge
    localparam logic [31:0] LFSR_SEED    = 32'h5764;
    localparam logic [1:0]  NOT_TAKEN    = 2'd0;
    localparam logic [1:0]  TAKEN        = 2'd1;
    localparam logic [1:0]  RANDOM       = 2'd2;

    typedef struct packed {
        word_t      fetch_pc;
        logic       check;        // compare the lookup on this row
        logic       res_valid;
        cf_kind_t   res_kind;
        word_t      res_pc;
        logic [1:0] taken_mode;
        word_t      res_target;
    } row_t;

    logic      clk;
    logic      arst_n;
    word_t     fetch_pc;
    logic      pred_hit;
    cf_kind_t  pred_kind;
    word_t     pred_target;
    logic      pred_taken;
    ghist_t    pred_global_index;
    ghist_t    pred_local_index;
    logic      resolve_valid;
    word_t     resolve_pc;
    cf_kind_t  resolve_kind;
    logic      resolve_taken;
    word_t     resolve_target;
    logic      resolve_pred_taken;
    ghist_t    resolve_global_index;
    ghist_t    resolve_local_index;
    perf_cnt_t num_control_flow;
    perf_cnt_t num_br;
    perf_cnt_t num_correct_predict;
    logic      num_control_flow_overflow;
    logic      num_br_overflow;
    logic      num_correct_predict_overflow;

    row_t        rows[$];
    logic        table_ready;
    logic [31:0] lfsr_state;

    // reference model state
    logic      m_valid  [BTB_ENTRIES];
    btb_tag_t  m_tag    [BTB_ENTRIES];
    cf_kind_t  m_kind   [BTB_ENTRIES];
    word_t     m_target [BTB_ENTRIES];
    ghist_t    m_ghist;
    ghist_t    m_lhist  [BHT_ENTRIES];
    ctr2_t     m_gpht   [2**HISTORY_DEPTH];
    ctr2_t     m_lpht   [2**HISTORY_DEPTH];
    ctr2_t     m_choice [2**CHOOSER_S_INDEX];
    perf_cnt_t m_cf;
    perf_cnt_t m_br;
    perf_cnt_t m_ok;
    int        chooser_migrations;

    branch_predictor u_dut (
        .clk                         (clk),
        .arst_n                      (arst_n),
        .fetch_pc                    (fetch_pc),
        .pred_hit                    (pred_hit),
        .pred_kind                   (pred_kind),
        .pred_target                 (pred_target),
        .pred_taken                  (pred_taken),
        .pred_global_index           (pred_global_index),
        .pred_local_index            (pred_local_index),
        .resolve_valid               (resolve_valid),
        .resolve_pc                  (resolve_pc),
        .resolve_kind                (resolve_kind),
        .resolve_taken               (resolve_taken),
        .resolve_target              (resolve_target),
        .resolve_pred_taken          (resolve_pred_taken),
        .resolve_global_index        (resolve_global_index),
        .resolve_local_index         (resolve_local_index),
        .num_control_flow            (num_control_flow),
        .num_br                      (num_br),
        .num_correct_predict         (num_correct_predict),
        .num_control_flow_overflow   (num_control_flow_overflow),
        .num_br_overflow             (num_br_overflow),
        .num_correct_predict_overflow(num_correct_predict_overflow)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("MISMATCH at %0t: %s got 0x%08h expected 0x%08h",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("MISMATCH at %0t: %s got %b expected %b",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_kind(input string name, input cf_kind_t got, input cf_kind_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("MISMATCH at %0t: %s got %s expected %s",
                                        $time, name, got.name(), exp.name()));
        end
    endtask

    task automatic check_cnt(input string name, input perf_cnt_t got, input perf_cnt_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("MISMATCH at %0t: %s got %0d expected %0d",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_hist(input string name, input ghist_t got, input ghist_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("MISMATCH at %0t: %s got %b expected %b",
                                        $time, name, got, exp));
        end
    endtask

    // right-shifting galois form, output bit is the one shifted out
    task automatic take_lfsr_bit(output logic b);
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
    endtask

    function automatic int slot_of(input word_t pc, input int bits);
        return int'((pc >> 2) % (1 << bits));   // word address modulo table size
    endfunction

    function automatic ctr2_t saturate(input ctr2_t c, input logic up);
        if (up) begin
            return (c == 2'd3) ? c : c + 2'd1;
        end
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    task automatic model_reset();
        foreach (m_valid[i]) begin
            m_valid[i]  = 1'b0;
            m_tag[i]    = '0;
            m_kind[i]   = cf_br;
            m_target[i] = '0;
        end
        foreach (m_lhist[i]) m_lhist[i] = '0;
        foreach (m_gpht[i]) m_gpht[i] = 2'b01;
        foreach (m_lpht[i]) m_lpht[i] = 2'b01;
        foreach (m_choice[i]) m_choice[i] = 2'b01;   // weakly prefer local
        m_ghist = '0;
        m_cf = '0;
        m_br = '0;
        m_ok = '0;
        chooser_migrations = 0;
    endtask

    task automatic model_predict(input word_t pc, output logic hit, output cf_kind_t kind,
                                 output word_t target, output logic taken,
                                 output ghist_t gi, output ghist_t li);
        int    b;
        ctr2_t sel;
        b      = slot_of(pc, BTB_S_INDEX);
        hit    = m_valid[b] && (m_tag[b] == btb_tag_t'(pc >> (BTB_S_INDEX + 2)));
        kind   = m_kind[b];
        target = m_target[b];
        gi     = m_ghist;
        li     = m_lhist[slot_of(pc, BHT_S_INDEX)];
        sel    = m_choice[slot_of(pc, CHOOSER_S_INDEX)][1] ? m_gpht[gi] : m_lpht[li];
        if (!hit) begin
            taken = 1'b0;
        end else begin
            taken = (kind == cf_br) ? sel[1] : 1'b1;
        end
    endtask

    task automatic model_update(input cf_kind_t kind, input word_t pc, input logic taken,
                                input word_t target, input logic pred,
                                input ghist_t gi, input ghist_t li);
        int    b;
        int    c;
        ctr2_t g;
        ctr2_t l;
        ctr2_t prev;
        b = slot_of(pc, BTB_S_INDEX);
        m_valid[b]  = 1'b1;
        m_tag[b]    = btb_tag_t'(pc >> (BTB_S_INDEX + 2));
        m_kind[b]   = kind;
        m_target[b] = (kind == cf_jalr) ? (target & ~32'd1) : target;
        m_cf++;
        if (kind == cf_br) begin
            m_br++;
            if (taken == pred) m_ok++;
            g = m_gpht[gi];
            l = m_lpht[li];
            if (g[1] != l[1]) begin                       // tables disagreed
                c = slot_of(pc, CHOOSER_S_INDEX);
                prev = m_choice[c];
                m_choice[c] = saturate(prev, g[1] == taken);
                if (!prev[1] && m_choice[c][1]) chooser_migrations++;   // now prefers global
            end
            m_gpht[gi] = saturate(g, taken);
            m_lpht[li] = saturate(l, taken);
            m_ghist = {m_ghist[HISTORY_DEPTH-2:0], taken};
            b = slot_of(pc, BHT_S_INDEX);
            m_lhist[b] = {m_lhist[b][HISTORY_DEPTH-2:0], taken};
        end
    endtask

    task automatic add_row(input word_t fetch, input logic check, input logic valid,
                           input cf_kind_t kind, input word_t pc, input logic [1:0] mode,
                           input word_t target);
        row_t r;
        r.fetch_pc   = fetch;
        r.check      = check;
        r.res_valid  = valid;
        r.res_kind   = kind;
        r.res_pc     = pc;
        r.taken_mode = mode;
        r.res_target = target;
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row(32'h0000_0000, 1, 0, cf_br, '0, NOT_TAKEN, '0);   // idle after reset
        add_row(32'h0000_0100, 1, 0, cf_br, '0, NOT_TAKEN, '0);
        add_row(32'h0000_1010, 1, 0, cf_br, '0, NOT_TAKEN, '0);
        add_row(32'h0000_0204, 1, 0, cf_br, '0, NOT_TAKEN, '0);
        add_row(32'h0000_1010, 1, 1, cf_jal, 32'h0000_1010, TAKEN, 32'h0000_2000);
        add_row(32'h0000_1010, 1, 1, cf_jalr, 32'h0000_1014, TAKEN, 32'h0000_3001);
        add_row(32'h0000_1014, 1, 0, cf_br, '0, NOT_TAKEN, '0);
        add_row(32'h0000_5010, 1, 0, cf_br, '0, NOT_TAKEN, '0);   // same index, other tag
        for (int i = 0; i < 24; i++) begin
            add_row(32'h0000_0100, 1, 1, cf_br, 32'h0000_0100, RANDOM, 32'h0000_0080);
        end
        for (int i = 0; i < 8; i++) begin                          // local and global split
            add_row(32'h0000_0204, 1, 1, cf_br, 32'h0000_0204, TAKEN, 32'h0000_0300);
            add_row(32'h0000_0208, 1, 1, cf_br, 32'h0000_0208, NOT_TAKEN, 32'h0000_0400);
        end
        add_row(32'h0000_0204, 1, 0, cf_br, '0, NOT_TAKEN, '0);
        add_row(32'h0000_0208, 1, 0, cf_br, '0, NOT_TAKEN, '0);
    endtask

    task automatic check_counters();
        check_cnt("num_control_flow", num_control_flow, m_cf);
        check_cnt("num_br", num_br, m_br);
        check_cnt("num_correct_predict", num_correct_predict, m_ok);
        check_bit("num_control_flow_overflow", num_control_flow_overflow, 1'b0);
        check_bit("num_br_overflow", num_br_overflow, 1'b0);
        check_bit("num_correct_predict_overflow", num_correct_predict_overflow, 1'b0);
    endtask

    initial begin
        int limit_ns;
        wait (table_ready === 1'b1);
        limit_ns = (RESET_CYCLES + rows.size() + 2) * CLK_PERIOD + 400;
        #(limit_ns);
        stop_with_failure($sformatf("timeout: run did not finish within %0d ns", limit_ns));
    end

    initial begin
        row_t     r;
        logic     taken;
        logic     rp_hit;
        cf_kind_t rp_kind;
        word_t    rp_target;
        logic     rp_taken;
        ghist_t   rp_gi;
        ghist_t   rp_li;
        logic     e_hit;
        cf_kind_t e_kind;
        word_t    e_target;
        logic     e_taken;
        ghist_t   e_gi;
        ghist_t   e_li;
        clk = 1'b0;
        arst_n = 1'b0;
        fetch_pc = '0;
        resolve_valid = 1'b0;
        resolve_pc = '0;
        resolve_kind = cf_br;
        resolve_taken = 1'b0;
        resolve_target = '0;
        resolve_pred_taken = 1'b0;
        resolve_global_index = '0;
        resolve_local_index = '0;
        lfsr_state = LFSR_SEED;
        table_ready = 1'b0;
        model_reset();
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY) arst_n = 1'b1;
        foreach (rows[i]) begin
            r = rows[i];
            @(posedge clk);
            #(DRIVE_DELAY);
            taken = r.taken_mode[0];
            if (r.res_valid && r.taken_mode == RANDOM) take_lfsr_bit(taken);
            // the caller hands back what fetch was told for this pc
            model_predict(r.res_pc, rp_hit, rp_kind, rp_target, rp_taken, rp_gi, rp_li);
            fetch_pc = r.fetch_pc;
            resolve_valid = r.res_valid;
            resolve_pc = r.res_pc;
            resolve_kind = r.res_kind;
            resolve_taken = taken;
            resolve_target = r.res_target;
            resolve_pred_taken = rp_taken;
            resolve_global_index = rp_gi;
            resolve_local_index = rp_li;
            #(SAMPLE_DELAY);
            if (r.check) begin
                model_predict(r.fetch_pc, e_hit, e_kind, e_target, e_taken, e_gi, e_li);
                check_bit("pred_hit", pred_hit, e_hit);
                if (e_hit) begin
                    check_kind("pred_kind", pred_kind, e_kind);
                    check_word("pred_target", pred_target, e_target);
                end
                check_bit("pred_taken", pred_taken, e_taken);
                check_hist("pred_global_index", pred_global_index, e_gi);
                check_hist("pred_local_index", pred_local_index, e_li);
            end
            check_counters();
            if (r.res_valid) begin
                model_update(r.res_kind, r.res_pc, taken, r.res_target, rp_taken, rp_gi, rp_li);
            end
        end
        @(posedge clk);
        #(DRIVE_DELAY) resolve_valid = 1'b0;
        #(SAMPLE_DELAY);
        check_counters();
        if (chooser_migrations == 0) begin
            stop_with_failure("the chooser never switched over to the global table");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule : tb_branch_predictor
